/* verilog/copro_pkg.sv */
// Coprocessor gateway definitions
package copro_pkg;

        // Decoded instruction word with its 3-bit tag.
        typedef struct packed {
                logic [2:0]  tag;
                logic [31:0] word;
        } instr_t;

        // Processor modes as held in the CPSR mode field.
        typedef enum logic [4:0] {
                USR = 5'b10000,
                FIQ = 5'b10001,
                IRQ = 5'b10010,
                SVC = 5'b10011,
                ABT = 5'b10111,
                UND = 5'b11011,
                SYS = 5'b11111
        } cpu_mode_t;

        ////////////////////////////////////////
        // Coprocessor opcode patterns for casez.
        ////////////////////////////////////////
        localparam logic [31:0] MRC  = 32'b????_1110_???1_????_????_????_???1_????;
        localparam logic [31:0] MCR  = 32'b????_1110_???0_????_????_????_???1_????;
        localparam logic [31:0] LDC  = 32'b????_110?_???1_????_????_????_????_????;
        localparam logic [31:0] STC  = 32'b????_110?_???0_????_????_????_????_????;
        localparam logic [31:0] CDP  = 32'b????_1110_????_????_????_????_???0_????;
        localparam logic [31:0] MRC2 = 32'b1111_1110_???1_????_????_????_???1_????;
        localparam logic [31:0] MCR2 = 32'b1111_1110_???0_????_????_????_???1_????;
        localparam logic [31:0] LDC2 = 32'b1111_110?_???1_????_????_????_????_????;
        localparam logic [31:0] STC2 = 32'b1111_110?_???0_????_????_????_????_????;

        // Coprocessor number field.
        localparam int          CP_NUM_LSB = 8;
        localparam int          CP_NUM_W   = 4;
        localparam logic [3:0]  CP15_NUM   = 4'd15;

        // Register transfer fields.
        localparam int          CRN_LSB    = 16;
        localparam int          RD_LSB     = 12;
        // Set for MRC, clear for MCR.
        localparam int          L_BIT      = 20;

        // Sizes.
        localparam int          NUM_CORE_REGS = 16;
        localparam int          NUM_CP_REGS   = 16;
        localparam int          REG_ADDR_W    = 4;
        localparam int          TRACK_W       = 3;

        // ANDNV R0, R0, R0. Condition NV means it never executes.
        localparam instr_t      NOP_INSTR = '{tag: 3'd0, word: {4'b1111, 28'd0}};

endpackage

/* verilog/copro_if.sv */
// Coprocessor request handshake
`timescale 1ns/100ps

interface copro_if;

        // Request valid, held until done is seen.
        logic        dav;
        // Instruction word, stable while dav is high.
        logic [31:0] word;
        // One-cycle completion pulse.
        logic        done;

        modport gateway
        (
                output dav,
                output word,
                input  done
        );

        modport copro
        (
                input  dav,
                input  word,
                output done
        );

endinterface

/* verilog/copro_reg_if.sv */
// Coprocessor register file port
`timescale 1ns/100ps

interface copro_reg_if import copro_pkg::*;
();

        // Access strobe and direction. wr high writes the core register.
        logic                  en;
        logic                  wr;
        logic [REG_ADDR_W-1:0] addr;
        logic [31:0]           wdata;
        // Read data, combinational from addr.
        logic [31:0]           rdata;

        modport regfile
        (
                input  en,
                input  wr,
                input  addr,
                input  wdata,
                output rdata
        );

        modport copro
        (
                output en,
                output wr,
                output addr,
                output wdata,
                input  rdata
        );

endinterface

/* verilog/predecode_coproc.sv */
// Coprocessor gateway
`timescale 1ns/100ps

module predecode_coproc import copro_pkg::*;
(
        input  logic      i_clk,
        input  logic      i_reset,

        // Instruction from upstream.
        input  instr_t    i_instruction,
        input  logic      i_valid,

        // CPSR state.
        input  logic      i_cpsr_ff_t,
        input  cpu_mode_t i_cpsr_ff_mode,

        input  logic      i_irq,
        input  logic      i_fiq,

        // Clears and stalls, highest priority first.
        input  logic      i_clear_from_writeback,
        input  logic      i_data_stall,
        input  logic      i_clear_from_alu,
        input  logic      i_stall_from_shifter,
        input  logic      i_stall_from_issue,

        // High while any instruction is still downstream.
        input  logic      i_pipeline_dav,

        copro_if.gateway  cp,

        output logic      o_irq,
        output logic      o_fiq,
        output instr_t    o_instruction,
        output logic      o_valid,
        output logic      o_stall_from_decode
);

typedef enum logic {IDLE, BUSY} state_t;

state_t      state_ff, state_nxt;
logic        dav_ff, dav_nxt;
logic [31:0] word_ff, word_nxt;
logic        is_copro_op;
logic        trap;
logic        advance;

////////////////////////////////////////
// Trap detection.
////////////////////////////////////////

// Any of the nine coprocessor opcodes.
always_comb
begin
        casez (i_instruction.word)
        MRC, MCR, LDC, STC, CDP, MRC2, MCR2, LDC2, STC2:
                is_copro_op = 1'b1;
        default:
                is_copro_op = 1'b0;
        endcase
end

// Only privileged ARM-state CP15 accesses with a clean tag are trapped.
assign trap = i_valid && !i_cpsr_ff_t && (i_instruction.tag == 3'd0) && is_copro_op &&
              (i_instruction.word[CP_NUM_LSB +: CP_NUM_W] == CP15_NUM) &&
              (i_cpsr_ff_mode != USR);

// Registers move only when nothing downstream holds or clears us.
assign advance = !(i_clear_from_writeback || i_data_stall || i_clear_from_alu ||
                   i_stall_from_shifter || i_stall_from_issue);

assign cp.dav  = dav_ff;
assign cp.word = word_ff;

////////////////////////////////////////
// Next state and outputs.
////////////////////////////////////////
always_comb
begin
        // Transparent by default.
        state_nxt           = state_ff;
        dav_nxt             = dav_ff;
        word_nxt            = word_ff;
        o_instruction       = i_instruction;
        o_valid             = i_valid;
        o_irq               = i_irq;
        o_fiq               = i_fiq;
        o_stall_from_decode = 1'b0;

        case (state_ff)
        IDLE:
        begin
                if (trap)
                begin
                        // Send a NOP down and hold upstream.
                        o_instruction       = NOP_INSTR;
                        o_valid             = 1'b0;
                        o_irq               = 1'b0;
                        o_fiq               = 1'b0;
                        o_stall_from_decode = 1'b1;

                        // Dispatch only once downstream is empty.
                        if (!i_pipeline_dav)
                        begin
                                word_nxt  = i_instruction.word;
                                dav_nxt   = 1'b1;
                                state_nxt = BUSY;
                        end
                end
        end
        BUSY:
        begin
                // Interrupts stay masked until the coprocessor finishes.
                o_instruction       = NOP_INSTR;
                o_valid             = 1'b0;
                o_irq               = 1'b0;
                o_fiq               = 1'b0;
                o_stall_from_decode = 1'b1;

                // Release upstream in the done cycle.
                if (cp.done)
                begin
                        o_stall_from_decode = 1'b0;
                        dav_nxt             = 1'b0;
                        state_nxt           = IDLE;
                end
        end
        endcase
end

// A data stall shields the ALU clear; the writeback clear beats both.
always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear_from_writeback || (i_clear_from_alu && !i_data_stall))
        begin
                state_ff <= IDLE;
                dav_ff   <= 1'b0;
        end
        else if (advance)
        begin
                state_ff <= state_nxt;
                dav_ff   <= dav_nxt;
        end
end

// Word latched for the coprocessor.
always_ff @(posedge i_clk)
begin
        if (advance)
        begin
                word_ff <= word_nxt;
        end
end

////////////////////////////////////////
// Checks.
////////////////////////////////////////

// Upstream is held and downstream stays empty while a request is outstanding.
a_dav_stall: assert property (@(posedge i_clk) disable iff (i_reset)
        cp.dav && !cp.done |-> o_stall_from_decode && !i_pipeline_dav);

// A request is withdrawn only after completion or a clear.
a_dav_release: assert property (@(posedge i_clk) disable iff (i_reset)
        $fell(cp.dav) |-> $past(cp.done || i_clear_from_writeback || i_clear_from_alu));

endmodule

/* verilog/cp15_unit.sv */
// CP15 system coprocessor
`timescale 1ns/100ps

module cp15_unit import copro_pkg::*;
(
        input  logic    i_clk,
        input  logic    i_reset,

        copro_if.copro  cp,
        copro_reg_if.copro rf
);

// System registers.
logic [31:0] sys_regs [NUM_CP_REGS];

// High in the execute cycle, one cycle after dav is first seen.
logic        busy_ff;
// Request word captured with dav.
logic [31:0] word_ff;
logic        is_xfer;
logic        is_mrc;
logic [REG_ADDR_W-1:0] crn;

// Register transfers only; CDP, LDC and STC just complete.
always_comb
begin
        casez (word_ff)
        MCR, MRC, MCR2, MRC2:
                is_xfer = 1'b1;
        default:
                is_xfer = 1'b0;
        endcase
end

assign is_mrc = word_ff[L_BIT];
assign crn    = word_ff[CRN_LSB +: REG_ADDR_W];

// Busy alternates so that a held dav never runs twice back to back.
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                busy_ff <= 1'b0;
        end
        else
        begin
                busy_ff <= cp.dav && !busy_ff;
        end
end

always_ff @(posedge i_clk)
begin
        if (cp.dav && !busy_ff)
        begin
                word_ff <= cp.word;
        end
end

// Done is the execute cycle itself.
assign cp.done = busy_ff;

////////////////////////////////////////
// Core register file access.
////////////////////////////////////////
assign rf.en    = busy_ff && is_xfer;
// MRC writes the core register, MCR reads it.
assign rf.wr    = is_mrc;
assign rf.addr  = word_ff[RD_LSB +: REG_ADDR_W];
assign rf.wdata = sys_regs[crn];

// MCR lands in the system register at the end of the done cycle.
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                for (int i = 0; i < NUM_CP_REGS; i++)
                begin
                        sys_regs[i] <= 32'd0;
                end
        end
        else if (busy_ff && is_xfer && !is_mrc)
        begin
                sys_regs[crn] <= rf.rdata;
        end
end

// A request still on the bus at completion carries the word just executed.
a_done_word: assert property (@(posedge i_clk) disable iff (i_reset)
        cp.done && cp.dav |-> (cp.word == word_ff));

endmodule

/* verilog/core_regfile.sv */
// Core register file
`timescale 1ns/100ps

module core_regfile import copro_pkg::*;
(
        input  logic                  i_clk,
        input  logic                  i_reset,

        // Writeback port.
        input  logic                  i_wb_en,
        input  logic [REG_ADDR_W-1:0] i_wb_addr,
        input  logic [31:0]           i_wb_data,

        // Operand read port.
        input  logic [REG_ADDR_W-1:0] i_rd_addr,
        output logic [31:0]           o_rd_data,

        copro_reg_if.regfile          rf
);

logic [31:0] regs [NUM_CORE_REGS];

// Two asynchronous read ports.
assign o_rd_data = regs[i_rd_addr];
assign rf.rdata  = regs[rf.addr];

// One write per cycle; writeback has priority.
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                for (int i = 0; i < NUM_CORE_REGS; i++)
                begin
                        regs[i] <= 32'd0;
                end
        end
        else if (i_wb_en)
        begin
                regs[i_wb_addr] <= i_wb_data;
        end
        else if (rf.en && rf.wr)
        begin
                regs[rf.addr] <= rf.wdata;
        end
end

// Writeback and MRC should never target one register together.
a_no_collision: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_wb_en && rf.en && rf.wr && (i_wb_addr == rf.addr)));

endmodule

/* verilog/drain_tracker.sv */
// In-flight instruction counter
`timescale 1ns/100ps

module drain_tracker import copro_pkg::*;
(
        input  logic i_clk,
        input  logic i_reset,
        input  logic i_issue,
        input  logic i_retire,
        input  logic i_flush,
        output logic o_pipeline_dav
);

logic [TRACK_W-1:0] count_ff;

// Saturating up/down count. A flush empties the pipe.
always_ff @(posedge i_clk)
begin
        if (i_reset || i_flush)
        begin
                count_ff <= '0;
        end
        else if (i_issue && !i_retire && (count_ff != '1))
        begin
                count_ff <= count_ff + 1'b1;
        end
        else if (i_retire && !i_issue && (count_ff != '0))
        begin
                count_ff <= count_ff - 1'b1;
        end
end

assign o_pipeline_dav = |count_ff;

// Issue and retire traffic stays inside the counter range.
a_no_wrap: assert property (@(posedge i_clk) disable iff (i_reset || i_flush)
        !(i_issue && !i_retire && (count_ff == '1)) &&
        !(i_retire && !i_issue && (count_ff == '0)));

endmodule

/* verilog/copro_subsys_top.sv */
// Coprocessor subsystem top
`timescale 1ns/100ps

module copro_subsys_top import copro_pkg::*;
(
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  instr_t                i_instruction,
        input  logic                  i_valid,
        input  logic                  i_cpsr_ff_t,
        input  cpu_mode_t             i_cpsr_ff_mode,
        input  logic                  i_irq,
        input  logic                  i_fiq,
        input  logic                  i_clear_from_writeback,
        input  logic                  i_data_stall,
        input  logic                  i_clear_from_alu,
        input  logic                  i_stall_from_shifter,
        input  logic                  i_stall_from_issue,
        input  logic                  i_retire,
        input  logic                  i_wb_en,
        input  logic [REG_ADDR_W-1:0] i_wb_addr,
        input  logic [31:0]           i_wb_data,
        input  logic [REG_ADDR_W-1:0] i_rd_addr,
        output logic [31:0]           o_rd_data,
        output logic                  o_irq,
        output logic                  o_fiq,
        output instr_t                o_instruction,
        output logic                  o_valid,
        output logic                  o_stall_from_decode
);

logic pipeline_dav;
logic issue;
logic flush;

copro_if     cp_bus ();
copro_reg_if rf_bus ();

// An instruction enters downstream only when no stage holds it back.
assign issue = o_valid && !i_data_stall && !i_stall_from_shifter && !i_stall_from_issue;
assign flush = i_clear_from_writeback || i_clear_from_alu;

predecode_coproc i_predecode_coproc
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_instruction          (i_instruction),
        .i_valid                (i_valid),
        .i_cpsr_ff_t            (i_cpsr_ff_t),
        .i_cpsr_ff_mode         (i_cpsr_ff_mode),
        .i_irq                  (i_irq),
        .i_fiq                  (i_fiq),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_stall_from_shifter   (i_stall_from_shifter),
        .i_stall_from_issue     (i_stall_from_issue),
        .i_pipeline_dav         (pipeline_dav),
        .cp                     (cp_bus.gateway),
        .o_irq                  (o_irq),
        .o_fiq                  (o_fiq),
        .o_instruction          (o_instruction),
        .o_valid                (o_valid),
        .o_stall_from_decode    (o_stall_from_decode)
);

cp15_unit i_cp15_unit
(
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .cp      (cp_bus.copro),
        .rf      (rf_bus.copro)
);

core_regfile i_core_regfile
(
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_wb_en   (i_wb_en),
        .i_wb_addr (i_wb_addr),
        .i_wb_data (i_wb_data),
        .i_rd_addr (i_rd_addr),
        .o_rd_data (o_rd_data),
        .rf        (rf_bus.regfile)
);

drain_tracker i_drain_tracker
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_issue        (issue),
        .i_retire       (i_retire),
        .i_flush        (flush),
        .o_pipeline_dav (pipeline_dav)
);

endmodule

/* sim/tb_copro_subsys.sv */
// Coprocessor subsystem testbench
`timescale 1ns/100ps

module tb_copro_subsys import copro_pkg::*;
();

localparam int MAX_TESTS       = 64;
localparam int CYCLES_PER_TEST = 20;
localparam int RESET_CYCLES    = 8;

logic                  i_clk;
logic                  i_reset;
instr_t                i_instruction;
logic                  i_valid;
logic                  i_cpsr_ff_t;
cpu_mode_t             i_cpsr_ff_mode;
logic                  i_irq;
logic                  i_fiq;
logic                  i_clear_from_writeback;
logic                  i_data_stall;
logic                  i_clear_from_alu;
logic                  i_stall_from_shifter;
logic                  i_stall_from_issue;
logic                  i_retire;
logic                  i_wb_en;
logic [REG_ADDR_W-1:0] i_wb_addr;
logic [31:0]           i_wb_data;
logic [REG_ADDR_W-1:0] i_rd_addr;
logic [31:0]           o_rd_data;
logic                  o_irq;
logic                  o_fiq;
instr_t                o_instruction;
logic                  o_valid;
logic                  o_stall_from_decode;

// Test table, one entry per line of the tests file.
logic [3:0]  t_kind  [MAX_TESTS];
logic [35:0] t_instr [MAX_TESTS];
logic [7:0]  t_mode  [MAX_TESTS];
logic        t_thumb [MAX_TESTS];
logic [31:0] t_data  [MAX_TESTS];
logic [31:0] t_exp   [MAX_TESTS];

int num_tests;
int errors;
int test_errors;
int cycle_count;
int cycle_limit;

copro_subsys_top i_copro_subsys_top
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_instruction          (i_instruction),
        .i_valid                (i_valid),
        .i_cpsr_ff_t            (i_cpsr_ff_t),
        .i_cpsr_ff_mode         (i_cpsr_ff_mode),
        .i_irq                  (i_irq),
        .i_fiq                  (i_fiq),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_stall_from_shifter   (i_stall_from_shifter),
        .i_stall_from_issue     (i_stall_from_issue),
        .i_retire               (i_retire),
        .i_wb_en                (i_wb_en),
        .i_wb_addr              (i_wb_addr),
        .i_wb_data              (i_wb_data),
        .i_rd_addr              (i_rd_addr),
        .o_rd_data              (o_rd_data),
        .o_irq                  (o_irq),
        .o_fiq                  (o_fiq),
        .o_instruction          (o_instruction),
        .o_valid                (o_valid),
        .o_stall_from_decode    (o_stall_from_decode)
);

// 10 ns clock.
always #5 i_clk = ~i_clk;

// Run limit from the number of test lines.
always @(posedge i_clk)
begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
                $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
                $display("=== FAIL ===");
                $finish;
        end
end

////////////////////////////////////////
// Stimulus helpers.
////////////////////////////////////////

task automatic compare(input string name, input logic [35:0] got, input logic [35:0] exp);
        if (got !== exp)
        begin
                $display("FAILED %s: got %h, expected %h", name, got, exp);
                test_errors++;
        end
endtask

// Inputs change 1 ns after the rising edge.
task automatic next_cycle();
        @(posedge i_clk);
        #1;
endtask

task automatic clear_inputs();
        i_reset                = 1'b0;
        i_instruction          = '0;
        i_valid                = 1'b0;
        i_cpsr_ff_t            = 1'b0;
        i_cpsr_ff_mode         = SVC;
        i_irq                  = 1'b0;
        i_fiq                  = 1'b0;
        i_clear_from_writeback = 1'b0;
        i_data_stall           = 1'b0;
        i_clear_from_alu       = 1'b0;
        i_stall_from_shifter   = 1'b0;
        i_stall_from_issue     = 1'b0;
        i_retire               = 1'b0;
        i_wb_en                = 1'b0;
        i_wb_addr              = '0;
        i_wb_data              = '0;
        i_rd_addr              = '0;
endtask

task automatic apply_reset();
        i_reset = 1'b1;
        repeat (RESET_CYCLES) next_cycle();
        i_reset = 1'b0;
endtask

// Read port is combinational.
task automatic read_core(input logic [3:0] addr, output logic [31:0] data);
        i_rd_addr = addr;
        #1;
        data = o_rd_data;
endtask

task automatic write_core(input logic [3:0] addr, input logic [31:0] data);
        i_wb_en   = 1'b1;
        i_wb_addr = addr;
        i_wb_data = data;
        next_cycle();
        i_wb_en   = 1'b0;
endtask

task automatic drive_instr(input logic [35:0] instr, input logic [7:0] mode, input logic thumb);
        i_instruction  = instr[34:0];
        i_valid        = 1'b1;
        i_irq          = 1'b1;
        i_fiq          = 1'b1;
        i_cpsr_ff_mode = cpu_mode_t'(mode[4:0]);
        i_cpsr_ff_t    = thumb;
endtask

task automatic drop_instr();
        i_instruction = '0;
        i_valid       = 1'b0;
        i_irq         = 1'b0;
        i_fiq         = 1'b0;
endtask

task automatic retire_one();
        i_retire = 1'b1;
        next_cycle();
        i_retire = 1'b0;
endtask

// Upstream holds the word until the stall falls in the done cycle.
task automatic wait_trap_done(output int stall_cycles);
        stall_cycles = 0;
        @(negedge i_clk);
        while (o_stall_from_decode === 1'b1)
        begin
                compare("o_valid", o_valid, 36'd0);
                compare("o_irq", o_irq, 36'd0);
                compare("o_fiq", o_fiq, 36'd0);
                stall_cycles++;
                @(posedge i_clk);
                @(negedge i_clk);
        end
        // Done cycle sends nothing down either.
        compare("o_valid", o_valid, 36'd0);
        next_cycle();
endtask

////////////////////////////////////////
// One test line.
////////////////////////////////////////
task automatic run_test(input int idx);
        logic [3:0]  rd;
        logic [31:0] value;
        int          n;

        rd = t_instr[idx][RD_LSB +: REG_ADDR_W];
        case (t_kind[idx])
        4'd0:
        begin
                // Everything is cleared by reset.
                apply_reset();
                @(negedge i_clk);
                compare("o_stall_from_decode", o_stall_from_decode, 36'd0);
                compare("o_valid", o_valid, 36'd0);
                next_cycle();
                for (int r = 0; r < NUM_CORE_REGS; r++)
                begin
                        read_core(r, value);
                        compare("o_rd_data", value, t_exp[idx]);
                        next_cycle();
                end
        end
        4'd1:
        begin
                // Zero-cycle pass-through, then check Rd was left alone.
                drive_instr(t_instr[idx], t_mode[idx], t_thumb[idx]);
                @(negedge i_clk);
                compare("o_instruction", o_instruction, t_instr[idx]);
                compare("o_valid", o_valid, 36'd1);
                compare("o_irq", o_irq, 36'd1);
                compare("o_fiq", o_fiq, 36'd1);
                compare("o_stall_from_decode", o_stall_from_decode, 36'd0);
                next_cycle();
                drop_instr();
                retire_one();
                read_core(rd, value);
                compare("o_rd_data", value, t_exp[idx]);
                next_cycle();
        end
        4'd2:
        begin
                // Load Rd by writeback, then trap the MCR.
                write_core(rd, t_data[idx]);
                drive_instr(t_instr[idx], t_mode[idx], t_thumb[idx]);
                wait_trap_done(n);
                compare("stall cycles", n, 36'd2);
                drop_instr();
        end
        4'd3:
        begin
                // Trapped MRC, CDP, LDC or STC.
                drive_instr(t_instr[idx], t_mode[idx], t_thumb[idx]);
                wait_trap_done(n);
                compare("stall cycles", n, 36'd2);
                drop_instr();
                read_core(rd, value);
                compare("o_rd_data", value, t_exp[idx]);
                next_cycle();
        end
        4'd4:
        begin
                // Three fillers in flight, no retire yet.
                i_instruction = {3'd0, t_data[idx]};
                i_valid       = 1'b1;
                repeat (3)
                begin
                        @(negedge i_clk);
                        compare("o_valid", o_valid, 36'd1);
                        next_cycle();
                end
                drive_instr(t_instr[idx], t_mode[idx], t_thumb[idx]);
                repeat (4)
                begin
                        @(negedge i_clk);
                        compare("o_stall_from_decode", o_stall_from_decode, 36'd1);
                        next_cycle();
                end
                // Stall holds through every retire.
                i_retire = 1'b1;
                repeat (3)
                begin
                        @(negedge i_clk);
                        compare("o_stall_from_decode", o_stall_from_decode, 36'd1);
                        next_cycle();
                end
                i_retire = 1'b0;
                wait_trap_done(n);
                compare("stall cycles", n, 36'd2);
                drop_instr();
                read_core(rd, value);
                compare("o_rd_data", value, t_exp[idx]);
                next_cycle();
        end
        4'd5:
        begin
                // One filler keeps the gateway waiting in IDLE.
                i_instruction = {3'd0, t_data[idx]};
                i_valid       = 1'b1;
                next_cycle();
                drive_instr(t_instr[idx], t_mode[idx], t_thumb[idx]);
                repeat (2)
                begin
                        @(negedge i_clk);
                        compare("o_stall_from_decode", o_stall_from_decode, 36'd1);
                        next_cycle();
                end
                i_clear_from_writeback = 1'b1;
                next_cycle();
                // Upstream is flushed and sends the next ordinary word.
                i_clear_from_writeback = 1'b0;
                i_instruction          = {3'd0, t_data[idx]};
                i_irq                  = 1'b0;
                i_fiq                  = 1'b0;
                @(negedge i_clk);
                compare("o_stall_from_decode", o_stall_from_decode, 36'd0);
                compare("o_valid", o_valid, 36'd1);
                compare("o_instruction", o_instruction.word, t_exp[idx]);
                next_cycle();
                drop_instr();
                retire_one();
                // The flushed filler no longer counts, so the trap dispatches at once.
                drive_instr(t_instr[idx], t_mode[idx], t_thumb[idx]);
                wait_trap_done(n);
                compare("stall cycles", n, 36'd2);
                drop_instr();
        end
        default:
        begin
                $display("Test %0d has an unknown kind %0d", idx, t_kind[idx]);
                test_errors++;
        end
        endcase
endtask

initial
begin : main
        int          fd;
        logic [3:0]  kind;
        logic [35:0] instr;
        logic [7:0]  mode;
        logic        thumb;
        logic [31:0] data;
        logic [31:0] exp;

        i_clk       = 1'b0;
        cycle_count = 0;
        num_tests   = 0;
        errors      = 0;
        clear_inputs();

        // Columns: kind, tag and word, mode, Thumb, data, expected.
        fd = $fopen("sim/copro_tests.txt", "r");
        if (fd != 0)
        begin
                while (num_tests < MAX_TESTS &&
                       $fscanf(fd, "%h %h %h %h %h %h\n", kind, instr, mode, thumb, data, exp) == 6)
                begin
                        t_kind[num_tests]  = kind;
                        t_instr[num_tests] = instr;
                        t_mode[num_tests]  = mode;
                        t_thumb[num_tests] = thumb;
                        t_data[num_tests]  = data;
                        t_exp[num_tests]   = exp;
                        num_tests++;
                end
                $fclose(fd);
        end
        else
        begin
                $display("Could not open the test file sim/copro_tests.txt");
        end
        cycle_limit = RESET_CYCLES + 2 + CYCLES_PER_TEST * num_tests;

        apply_reset();
        if (num_tests == 0)
        begin
                $display("No test lines were read");
                errors = 1;
        end
        for (int t = 0; t < num_tests; t++)
        begin
                test_errors = 0;
                run_test(t);
                $display("Test %0d (kind %0d): %s", t, t_kind[t],
                         (test_errors == 0) ? "ok" : "mismatch");
                errors += test_errors;
        end

        $display("%0d tests run, %0d errors", num_tests, errors);
        if (errors == 0)
        begin
                $display("=== PASS ===");
        end
        else
        begin
                $display("=== FAIL ===");
        end
        $finish;
end

endmodule

/* sources.f */
verilog/copro_pkg.sv
verilog/copro_if.sv
verilog/copro_reg_if.sv
verilog/predecode_coproc.sv
verilog/cp15_unit.sv
verilog/core_regfile.sv
verilog/drain_tracker.sv
verilog/copro_subsys_top.sv
sim/tb_copro_subsys.sv

/* sim/copro_tests.txt */
0 000000000 13 0 00000000 00000000
1 0E0811002 13 0 00000000 00000000
2 0EE023F10 13 0 12345678 00000000
3 0EE127F10 13 0 00000000 12345678
1 0EE023F10 10 0 00000000 12345678
1 0EE023F10 13 1 00000000 12345678
1 0EE023E10 13 0 00000000 12345678
1 0EE125F10 10 0 00000000 00000000
1 1EE125F10 13 0 00000000 00000000
1 0EE125E10 1F 0 00000000 00000000
2 0EE05AF10 1F 0 CAFEF00D 00000000
3 0EE15BF10 11 0 00000000 CAFEF00D
3 0EE000F00 13 0 00000000 00000000
3 0ED901F00 13 0 00000000 00000000
3 0FE129F10 13 0 00000000 12345678
4 0EE128F10 13 0 E1A00000 12345678
5 0EE023F10 13 0 E0811002 E0811002
3 0EE15CF10 13 0 00000000 CAFEF00D
0 000000000 13 0 00000000 00000000
